/* hw/core_settings.svh */
/*
 * shared constants for the settings, pad and video blocks
 * bridge offsets, analogizer word layout, reset and sync timing
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// core reset countdown length, kept short for simulation
`define CORE_RESET_CYCLES 32'd16

// bridge register offsets, low 12 address bits
`define OFS_RESET         12'h050
`define OFS_HIDE_OVERSCAN 12'h200
`define OFS_SQUARE_PIXELS 12'h210
`define OFS_REGION        12'h330

// analogizer config page, compared with address bits 31:24
`define ANALOGIZER_PAGE 8'hF7

// analogizer word fields
`define SNAC_TYPE_LSB    0
`define SNAC_ASSIGN_LSB  8
`define POCKET_BLANK_BIT 16

// hs pulse delay after the core's hs rise
`define HS_DELAY_CYCLES 3'd7

// flag positions in the end-of-line slot word
`define SLOT_HIDE_BIT   14
`define SLOT_SQUARE_BIT 13

`endif

/* hw/core_cfg_pkg.sv */
/*
 * bridge bus, region, pixel and reset countdown types
 */
package core_cfg_pkg;

  //////////////////////////////
  // bridge bus

  // address, page in [31:24], register offset in [11:0]
  typedef logic [31:0] bridge_addr_t;

  // one bridge data word, read or write
  typedef logic [31:0] bridge_data_t;

  //////////////////////////////
  // console settings

  // region code
  // 0 ntsc, 1 pal, 2 dendy
  typedef logic [1:0] region_t;

  // overscan hiding only applies to ntsc
  localparam region_t REGION_NTSC = 2'd0;

  // length of the host requested core reset
  typedef logic [31:0] reset_count_t;

  //////////////////////////////
  // video

  // pixel word
  //   [23:16] red
  //   [15:8]  green
  //   [7:0]   blue
  typedef logic [23:0] rgb_t;

endpackage

/* hw/pad_pkg.sv */
/*
 * controller key and stick types, snac type and route codes
 */
package pad_pkg;

  // key bitmap, pocket layout
  //   [3:0]  dpad up, down, left, right
  //   [7:4]  face a, b, x, y
  //   [13:8] l1, r1, l2, r2, l3, r3
  //   [15:14] select, start
  typedef logic [15:0] pad_keys_t;

  // stick word, unsigned, 0x80 centered
  //   [7:0] lx, [15:8] ly, [23:16] rx, [31:24] ry
  typedef logic [31:0] pad_joy_t;

  localparam pad_joy_t JOY_NEUTRAL = 32'h8080_8080;

  // snac controller type
  typedef logic [4:0] snac_type_t;

  localparam snac_type_t SNAC_TYPE_OFF      = 5'h00;
  localparam snac_type_t SNAC_TYPE_ANALOG_A = 5'h12;
  localparam snac_type_t SNAC_TYPE_ANALOG_B = 5'h13;

  // snac to pocket player route
  typedef logic [2:0] snac_assign_t;

  localparam snac_assign_t SNAC_TO_P1      = 3'd0;
  localparam snac_assign_t SNAC_TO_P2      = 3'd1;
  localparam snac_assign_t SNAC_TO_P1_P2   = 3'd2;
  localparam snac_assign_t SNAC_SWAP_P1_P2 = 3'd3;
  localparam snac_assign_t SNAC_TO_P3_P4   = 3'd4;
  localparam snac_assign_t SNAC_TO_ALL     = 3'd5;

endpackage

/* hw/core_settings_if.sv */
/*
 * live core settings, from the bridge registers
 * to the pad router and the video shaper
 */
`timescale 1ns/100ps

interface core_settings_if
  import core_cfg_pkg::*;
  import pad_pkg::*;
();

  // console and video settings
  region_t      region;
  logic         hide_overscan;
  logic         square_pixels;
  logic         pocket_blank;

  // analogizer controller settings
  snac_type_t   snac_type;
  snac_assign_t snac_assign;

  modport regs (
    output region,
    output hide_overscan,
    output square_pixels,
    output pocket_blank,
    output snac_type,
    output snac_assign
  );

  modport pad (
    input snac_type,
    input snac_assign
  );

  modport video (
    input region,
    input hide_overscan,
    input square_pixels,
    input pocket_blank
  );

endinterface

/* hw/host_settings_regs.sv */
/*
 * bridge settings registers and analogizer config word
 * core reset countdown and region change pulse
 */
`timescale 1ns/100ps
`include "core_settings.svh"

module host_settings_regs
  import core_cfg_pkg::*;
  import pad_pkg::*;
(
  input  logic          clk_ppu_21_47,
  input  logic          pll_core_locked,
  input  bridge_addr_t  bridge_addr,
  input  logic          bridge_wr,
  input  bridge_data_t  bridge_wr_data,
  output bridge_data_t  bridge_rd_data,
  output logic          core_reset,
  core_settings_if.regs settings
);

  bridge_data_t analogizer_word;
  region_t      region;
  region_t      region_prev;
  logic         hide_overscan;
  logic         square_pixels;
  logic         region_pulse;
  reset_count_t reset_count;
  logic         analogizer_sel;

  assign analogizer_sel = (bridge_addr[31:24] == `ANALOGIZER_PAGE);

  //////////////////////////////
  // bridge write decode

  always_ff @(posedge clk_ppu_21_47 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      analogizer_word <= '0;
      region          <= '0;
      hide_overscan   <= 1'b0;
      square_pixels   <= 1'b0;
      reset_count     <= '0;
    end else begin
      if (reset_count != '0) begin
        reset_count <= reset_count - reset_count_t'(1);
      end

      if (bridge_wr && analogizer_sel) begin
        analogizer_word <= bridge_wr_data;
      end else if (bridge_wr) begin
        // a new reset request restarts the countdown
        case (bridge_addr[11:0])
          `OFS_RESET:         reset_count   <= `CORE_RESET_CYCLES;
          `OFS_HIDE_OVERSCAN: hide_overscan <= bridge_wr_data[0];
          `OFS_SQUARE_PIXELS: square_pixels <= bridge_wr_data[0];
          `OFS_REGION:        region        <= bridge_wr_data[$bits(region_t)-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////
  // core reset

  // one cycle pulse after the region register changes
  always_ff @(posedge clk_ppu_21_47 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      region_prev  <= '0;
      region_pulse <= 1'b0;
    end else begin
      region_prev  <= region;
      region_pulse <= (region != region_prev);
    end
  end

  assign core_reset = region_pulse || (reset_count != '0);

  //////////////////////////////
  // settings out and read back

  assign settings.region        = region;
  assign settings.hide_overscan = hide_overscan;
  assign settings.square_pixels = square_pixels;
  assign settings.snac_type     = analogizer_word[`SNAC_TYPE_LSB +: $bits(snac_type_t)];
  assign settings.snac_assign   = analogizer_word[`SNAC_ASSIGN_LSB +: $bits(snac_assign_t)];
  assign settings.pocket_blank  = analogizer_word[`POCKET_BLANK_BIT];

  // only the analogizer page reads back
  assign bridge_rd_data = analogizer_sel ? analogizer_word : '0;

endmodule

/* hw/snac_pad_router.sv */
/*
 * per player choice of pocket or snac pad data
 * stick forced neutral for digital snac pads
 */
`timescale 1ns/100ps

module snac_pad_router
  import pad_pkg::*;
(
  input  logic         clk_ppu_21_47,
  input  logic         pll_core_locked,
  core_settings_if.pad settings,
  input  pad_keys_t    cont1_key,
  input  pad_keys_t    cont2_key,
  input  pad_keys_t    cont3_key,
  input  pad_keys_t    cont4_key,
  input  pad_joy_t     cont1_joy,
  input  pad_keys_t    snac_p1_btn,
  input  pad_keys_t    snac_p2_btn,
  input  pad_keys_t    snac_p3_btn,
  input  pad_keys_t    snac_p4_btn,
  input  pad_joy_t     snac_p1_joy,
  input  pad_joy_t     snac_p2_joy,
  output pad_keys_t    p1_controls,
  output pad_keys_t    p2_controls,
  output pad_keys_t    p3_controls,
  output pad_keys_t    p4_controls,
  output pad_joy_t     p1_joystick
);

  logic      snac_is_analog;
  pad_joy_t  snac1_stick;
  pad_joy_t  snac2_stick;
  pad_keys_t p1_next;
  pad_keys_t p2_next;
  pad_keys_t p3_next;
  pad_keys_t p4_next;
  pad_joy_t  p1_joy_next;

  assign snac_is_analog = (settings.snac_type == SNAC_TYPE_ANALOG_A) ||
                          (settings.snac_type == SNAC_TYPE_ANALOG_B);

  // digital pads have no stick
  assign snac1_stick = snac_is_analog ? snac_p1_joy : JOY_NEUTRAL;
  assign snac2_stick = snac_is_analog ? snac_p2_joy : JOY_NEUTRAL;

  always_comb begin
    p1_next     = cont1_key;
    p2_next     = cont2_key;
    p3_next     = cont3_key;
    p4_next     = cont4_key;
    p1_joy_next = cont1_joy;

    if (settings.snac_type != SNAC_TYPE_OFF) begin
      case (settings.snac_assign)
        SNAC_TO_P1: begin
          p1_next     = snac_p1_btn;
          p1_joy_next = snac1_stick;
        end
        SNAC_TO_P2: begin
          p2_next = snac_p1_btn;
        end
        SNAC_TO_P1_P2: begin
          p1_next     = snac_p1_btn;
          p2_next     = snac_p2_btn;
          p1_joy_next = snac1_stick;
        end
        SNAC_SWAP_P1_P2: begin
          p1_next     = snac_p2_btn;
          p2_next     = snac_p1_btn;
          p1_joy_next = snac2_stick;
        end
        // p1 keeps its pocket stick here
        SNAC_TO_P3_P4: begin
          p3_next = snac_p1_btn;
          p4_next = snac_p2_btn;
        end
        SNAC_TO_ALL: begin
          p1_next     = snac_p1_btn;
          p2_next     = snac_p2_btn;
          p3_next     = snac_p3_btn;
          p4_next     = snac_p4_btn;
          p1_joy_next = snac1_stick;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_ppu_21_47 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      p1_controls <= '0;
      p2_controls <= '0;
      p3_controls <= '0;
      p4_controls <= '0;
      p1_joystick <= '0;
    end else begin
      p1_controls <= p1_next;
      p2_controls <= p2_next;
      p3_controls <= p3_next;
      p4_controls <= p4_next;
      p1_joystick <= p1_joy_next;
    end
  end

endmodule

/* hw/video_sync_shaper.sv */
/*
 * registered de and rgb toward the scaler, slot word at end of line
 * delayed hs pulse and single cycle vs pulse
 */
`timescale 1ns/100ps
`include "core_settings.svh"

module video_sync_shaper
  import core_cfg_pkg::*;
(
  input  logic           clk_ppu_21_47,
  input  logic           pll_core_locked,
  core_settings_if.video settings,
  input  logic           nes_h_blank,
  input  logic           nes_v_blank,
  input  logic           nes_hs,
  input  logic           nes_vs,
  input  rgb_t           nes_rgb,
  output rgb_t           video_rgb,
  output logic           video_de,
  output logic           video_hs,
  output logic           video_vs
);

  logic       active;
  rgb_t       slot_word;
  logic       hs_prev;
  logic       vs_prev;
  logic [2:0] hs_count;

  assign active = !(nes_h_blank || nes_v_blank);

  // scaler slot word, sent once per line
  always_comb begin
    slot_word = '0;
    slot_word[`SLOT_HIDE_BIT]   = settings.hide_overscan && (settings.region == REGION_NTSC);
    slot_word[`SLOT_SQUARE_BIT] = settings.square_pixels;
  end

  //////////////////////////////
  // de and pixel data

  // video_de also serves as the previous de sample
  always_ff @(posedge clk_ppu_21_47 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
    end else begin
      video_de <= active;
      if (active) begin
        video_rgb <= settings.pocket_blank ? '0 : nes_rgb;
      end else if (video_de) begin
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

  //////////////////////////////
  // sync pulses

  // hs pushed back so it never lands on the vs pulse
  always_ff @(posedge clk_ppu_21_47 or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_count <= '0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      hs_prev  <= nes_hs;
      vs_prev  <= nes_vs;
      video_vs <= nes_vs && !vs_prev;
      video_hs <= (hs_count == 3'd1);

      if (nes_hs && !hs_prev) begin
        hs_count <= `HS_DELAY_CYCLES;
      end else if (hs_count != '0) begin
        hs_count <= hs_count - 3'd1;
      end
    end
  end

endmodule

/* hw/core_top.sv */
/*
 * core housekeeping top level
 * settings registers, snac pad router and video output shaper
 */
`timescale 1ns/100ps

module core_top
  import core_cfg_pkg::*;
  import pad_pkg::*;
(
  input  logic         clk_ppu_21_47,
  input  logic         pll_core_locked,

  // bridge
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  output bridge_data_t bridge_rd_data,
  output logic         core_reset,

  // pocket and snac pads
  input  pad_keys_t    cont1_key,
  input  pad_keys_t    cont2_key,
  input  pad_keys_t    cont3_key,
  input  pad_keys_t    cont4_key,
  input  pad_joy_t     cont1_joy,
  input  pad_keys_t    snac_p1_btn,
  input  pad_keys_t    snac_p2_btn,
  input  pad_keys_t    snac_p3_btn,
  input  pad_keys_t    snac_p4_btn,
  input  pad_joy_t     snac_p1_joy,
  input  pad_joy_t     snac_p2_joy,
  output pad_keys_t    p1_controls,
  output pad_keys_t    p2_controls,
  output pad_keys_t    p3_controls,
  output pad_keys_t    p4_controls,
  output pad_joy_t     p1_joystick,

  // video from the core and toward the scaler
  input  logic         nes_h_blank,
  input  logic         nes_v_blank,
  input  logic         nes_hs,
  input  logic         nes_vs,
  input  rgb_t         nes_rgb,
  output rgb_t         video_rgb,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs
);

  core_settings_if settings_if ();

  host_settings_regs host_settings_regs_i (
    .*,
    .settings (settings_if.regs)
  );

  snac_pad_router snac_pad_router_i (
    .*,
    .settings (settings_if.pad)
  );

  video_sync_shaper video_sync_shaper_i (
    .*,
    .settings (settings_if.video)
  );

endmodule

/* dv/core_top_tb.sv */
/*
 * core_top testbench with clock, reset, bridge and pad stimulus
 * route and slot reference functions and a comparing process for the pads
 */
`timescale 1ns/100ps
`include "core_settings.svh"

module core_top_tb;

  logic        clk_ppu_21_47;
  logic        pll_core_locked;
  logic [31:0] bridge_addr;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] bridge_rd_data;
  logic        core_reset;
  logic [15:0] cont1_key, cont2_key, cont3_key, cont4_key;
  logic [31:0] cont1_joy;
  logic [15:0] snac_p1_btn, snac_p2_btn, snac_p3_btn, snac_p4_btn;
  logic [31:0] snac_p1_joy, snac_p2_joy;
  logic [15:0] p1_controls, p2_controls, p3_controls, p4_controls;
  logic [31:0] p1_joystick;
  logic        nes_h_blank, nes_v_blank, nes_hs, nes_vs;
  logic [23:0] nes_rgb;
  logic [23:0] video_rgb;
  logic        video_de, video_hs, video_vs;

  // shadow of the analogizer settings as last written
  logic [4:0]  cfg_type;
  logic [2:0]  cfg_assign;
  logic        pad_chk_en;
  logic        pad_exp_en;
  logic [95:0] pad_exp;
  logic [31:0] lcg_state;

  core_top core_top_i (.*);

  always #10 clk_ppu_21_47 = ~clk_ppu_21_47;

  //////////////////////////////
  // helpers

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      fail_run($sformatf("CHECK FAILED: %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  // next edge and on to the drive point
  task automatic step();
    @(posedge clk_ppu_21_47);
    #2;
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    step();
    bridge_wr      = 1'b0;
  endtask

  function automatic logic [31:0] analogizer_word(input logic [4:0] typ, input logic [2:0] asg,
                                                  input logic blank);
    logic [31:0] w;
    w = '0;
    w[`SNAC_TYPE_LSB +: 5]   = typ;
    w[`SNAC_ASSIGN_LSB +: 3] = asg;
    w[`POCKET_BLANK_BIT]     = blank;
    return w;
  endfunction

  task automatic drive_random_pads();
    cont1_key   = 16'(lcg_next());
    cont2_key   = 16'(lcg_next());
    cont3_key   = 16'(lcg_next());
    cont4_key   = 16'(lcg_next());
    cont1_joy   = lcg_next();
    snac_p1_btn = 16'(lcg_next());
    snac_p2_btn = 16'(lcg_next());
    snac_p3_btn = 16'(lcg_next());
    snac_p4_btn = 16'(lcg_next());
    snac_p1_joy = lcg_next();
    snac_p2_joy = lcg_next();
  endtask

  //////////////////////////////
  // reference models

  // {p1, p2, p3, p4, p1 stick}
  function automatic logic [95:0] route_ref(input logic [4:0] typ, input logic [2:0] asg);
    logic [15:0] k1, k2, k3, k4;
    logic [31:0] joy, stick1, stick2;
    logic        analog;
    k1     = cont1_key;
    k2     = cont2_key;
    k3     = cont3_key;
    k4     = cont4_key;
    joy    = cont1_joy;
    analog = (typ == 5'h12) || (typ == 5'h13);
    stick1 = analog ? snac_p1_joy : 32'h8080_8080;
    stick2 = analog ? snac_p2_joy : 32'h8080_8080;
    if (typ != 5'h00) begin
      case (asg)
        3'd0: begin
          k1  = snac_p1_btn;
          joy = stick1;
        end
        3'd1: k2 = snac_p1_btn;
        3'd2: begin
          k1  = snac_p1_btn;
          k2  = snac_p2_btn;
          joy = stick1;
        end
        3'd3: begin
          k1  = snac_p2_btn;
          k2  = snac_p1_btn;
          joy = stick2;
        end
        3'd4: begin
          k3 = snac_p1_btn;
          k4 = snac_p2_btn;
        end
        3'd5: begin
          k1  = snac_p1_btn;
          k2  = snac_p2_btn;
          k3  = snac_p3_btn;
          k4  = snac_p4_btn;
          joy = stick1;
        end
        default: ;
      endcase
    end
    return {k1, k2, k3, k4, joy};
  endfunction

  function automatic logic [23:0] slot_ref(input logic hide, input logic square,
                                           input logic [1:0] region);
    logic [23:0] w;
    w = '0;
    w[`SLOT_HIDE_BIT]   = hide && (region == 2'd0);
    w[`SLOT_SQUARE_BIT] = square;
    return w;
  endfunction

  // pad outputs against the inputs seen at the previous edge
  always begin
    @(posedge clk_ppu_21_47);
    pad_exp    = route_ref(cfg_type, cfg_assign);
    pad_exp_en = pad_chk_en;
    @(negedge clk_ppu_21_47);
    if (pad_exp_en) begin
      check_value("route p1_controls", pad_exp[95:80], p1_controls);
      check_value("route p2_controls", pad_exp[79:64], p2_controls);
      check_value("route p3_controls", pad_exp[63:48], p3_controls);
      check_value("route p4_controls", pad_exp[47:32], p4_controls);
      check_value("route p1_joystick", pad_exp[31:0], p1_joystick);
    end
  end

  // one line of active video and the slot word cycle after it
  task automatic end_line_check(input string name, input logic [23:0] exp);
    nes_h_blank = 1'b0;
    nes_v_blank = 1'b0;
    nes_rgb     = 24'(lcg_next());
    step();
    nes_h_blank = 1'b1;
    step();
    check_value({name, " de"}, 32'd0, video_de);
    check_value({name, " slot word"}, exp, video_rgb);
    step();
    check_value({name, " after slot"}, 32'd0, video_rgb);
  endtask

  //////////////////////////////
  // stimulus

  initial begin
    int          n;
    logic [23:0] pix;
    logic [4:0]  types [3];
    clk_ppu_21_47   = 1'b0;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    lcg_state       = 32'd68245;
    drive_random_pads();
    nes_h_blank = 1'b1;
    nes_v_blank = 1'b1;
    nes_hs      = 1'b0;
    nes_vs      = 1'b0;
    nes_rgb     = '0;
    cfg_type    = '0;
    cfg_assign  = '0;
    pad_chk_en  = 1'b0;
    types       = '{5'h00, 5'h01, 5'h12};

    repeat (5) @(posedge clk_ppu_21_47);
    #2;
    bridge_addr = 32'hF700_0000;
    #1;
    check_value("reset p1_controls", 32'd0, p1_controls);
    check_value("reset p2_controls", 32'd0, p2_controls);
    check_value("reset p3_controls", 32'd0, p3_controls);
    check_value("reset p4_controls", 32'd0, p4_controls);
    check_value("reset p1_joystick", 32'd0, p1_joystick);
    check_value("reset core_reset", 32'd0, core_reset);
    check_value("reset analogizer read", 32'd0, bridge_rd_data);
    pll_core_locked = 1'b1;
    step();

    // analogizer readback and a zero read from another page
    bridge_write(32'hF700_0000, 32'h0001_0512);
    #1;
    check_value("analogizer readback", 32'h0001_0512, bridge_rd_data);
    bridge_addr = 32'h1200_0000;
    #1;
    check_value("other page read", 32'd0, bridge_rd_data);

    // reset countdown length
    bridge_write({20'h0, `OFS_RESET}, 32'd1);
    n = 0;
    while (core_reset === 1'b1 && n <= 100) begin
      n++;
      step();
    end
    if (n > 100) fail_run("core_reset stayed high past its countdown");
    check_value("core reset length", `CORE_RESET_CYCLES, n);

    // region change pulse
    bridge_write({20'h0, `OFS_REGION}, 32'd1);
    n = 0;
    while (core_reset !== 1'b1 && n < 10) begin
      step();
      n++;
    end
    if (core_reset !== 1'b1) fail_run("core_reset never pulsed after a region change");
    check_value("region pulse delay", 32'd1, n);
    step();
    check_value("region pulse width", 32'd0, core_reset);

    // pad routing over types and routes
    for (int ti = 0; ti < 3; ti++) begin
      for (int asg = 0; asg < 8; asg++) begin
        pad_chk_en = 1'b0;
        cfg_type   = types[ti];
        cfg_assign = asg[2:0];
        bridge_write(32'hF700_0000, analogizer_word(cfg_type, cfg_assign, 1'b0));
        pad_chk_en = 1'b1;
        repeat (4) begin
          drive_random_pads();
          step();
        end
      end
    end
    pad_chk_en = 1'b0;

    // active video with and without pocket blank
    nes_h_blank = 1'b0;
    nes_v_blank = 1'b0;
    repeat (6) begin
      pix     = 24'(lcg_next());
      nes_rgb = pix;
      step();
      check_value("active de", 32'd1, video_de);
      check_value("active rgb", pix, video_rgb);
    end
    bridge_write(32'hF700_0000, analogizer_word(5'h00, 3'd0, 1'b1));
    repeat (6) begin
      nes_rgb = 24'(lcg_next());
      step();
      check_value("blanked de", 32'd1, video_de);
      check_value("blanked rgb", 32'd0, video_rgb);
    end
    bridge_write(32'hF700_0000, 32'd0);
    nes_h_blank = 1'b1;

    // slot word variants
    bridge_write({20'h0, `OFS_HIDE_OVERSCAN}, 32'd1);
    bridge_write({20'h0, `OFS_REGION}, 32'd0);
    end_line_check("slot hide ntsc", slot_ref(1'b1, 1'b0, 2'd0));
    bridge_write({20'h0, `OFS_REGION}, 32'd1);
    end_line_check("slot hide pal", slot_ref(1'b1, 1'b0, 2'd1));
    bridge_write({20'h0, `OFS_HIDE_OVERSCAN}, 32'd0);
    bridge_write({20'h0, `OFS_SQUARE_PIXELS}, 32'd1);
    end_line_check("slot square", slot_ref(1'b0, 1'b1, 2'd1));

    // vs pulse one edge after the rise
    nes_vs = 1'b1;
    step();
    check_value("vs pulse", 32'd1, video_vs);
    step();
    check_value("vs pulse width", 32'd0, video_vs);
    nes_vs = 1'b0;

    // hs pulse after the delay
    nes_hs = 1'b1;
    step();
    n = 0;
    while (video_hs !== 1'b1 && n < 20) begin
      step();
      n++;
    end
    if (video_hs !== 1'b1) fail_run("video_hs never pulsed after the hs rise");
    check_value("hs pulse delay", `HS_DELAY_CYCLES, n);
    step();
    check_value("hs pulse width", 32'd0, video_hs);
    nes_hs = 1'b0;
    step();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* build.f */
+incdir+hw
hw/core_cfg_pkg.sv
hw/pad_pkg.sv
hw/core_settings_if.sv
hw/host_settings_regs.sv
hw/snac_pad_router.sv
hw/video_sync_shaper.sv
hw/core_top.sv
dv/core_top_tb.sv

/* Bender.yml */
package:
  name: core_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_cfg_pkg.sv
      - hw/pad_pkg.sv
      - hw/core_settings_if.sv
      - hw/host_settings_regs.sv
      - hw/snac_pad_router.sv
      - hw/video_sync_shaper.sv
      - hw/core_top.sv
      - target: test
        files:
          - dv/core_top_tb.sv
